//--- project.f
verilog/rv32_pkg.sv
verilog/register_file.sv
verilog/fetch_unit.sv
verilog/decode_stage.sv
verilog/hazard_unit.sv
verilog/execute_stage.sv
verilog/memory_writeback.sv
verilog/datapath.sv
bench/datapath_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build the datapath testbench with Verilator, run it, then check the log.
set -u
cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log

if ! command -v verilator > /dev/null 2>&1; then
    echo "verilator not found in PATH"
    exit 1
fi

verilator --binary --timing --assert -f project.f --top-module datapath_tb -Mdir "$BUILD_DIR"
if [ $? -ne 0 ]; then
    echo "build step returned an error"
    exit 1
fi

"./$BUILD_DIR/Vdatapath_tb" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulator exited with status $status"
    exit 1
fi

if grep -qx "Simulation completed successfully" "$LOG"; then
    exit 0
fi
exit 1

//--- bench/datapath_patterns.hex
// one hex word per entry: program length N, then N instruction words,
// store count M, then M rows of expected store address and store data
00000024  // N = 36
05500093  // 00 addi x1, x0, 0x55
00f00113  // 01 addi x2, x0, 15
002081b3  // 02 add  x3, x1, x2     0x64
40118233  // 03 sub  x4, x3, x1     0x0f
003242b3  // 04 xor  x5, x4, x3     0x6b
0022e333  // 05 or   x6, x5, x2     0x6f
004373b3  // 06 and  x7, x6, x4     0x0f
00702023  // 07 sw   x7, 0(x0)
80000437  // 08 lui  x8, 0x80000
ff000493  // 09 addi x9, x0, -16
4024d513  // 10 srai x10, x9, 2     0xfffffffc
0024d5b3  // 11 srl  x11, x9, x2    0x0001ffff
40245633  // 12 sra  x12, x8, x2    0xffff0000
0014a6b3  // 13 slt  x13, x9, x1    1
0014b733  // 14 sltu x14, x9, x1    0
fff44793  // 15 xori x15, x8, -1    0x7fffffff
00a02223  // 16 sw   x10, 4(x0)
00b02423  // 17 sw   x11, 8(x0)
00c02623  // 18 sw   x12, 12(x0)
00d02823  // 19 sw   x13, 16(x0)
00e02a23  // 20 sw   x14, 20(x0)
00f02c23  // 21 sw   x15, 24(x0)
12300813  // 22 addi x16, x0, 0x123
00409893  // 23 slli x17, x1, 4     0x550
40086913  // 24 ori  x18, x16, 0x400  distance two
0f087993  // 25 andi x19, x16, 0xf0   distance three
01202e23  // 26 sw   x18, 28(x0)
03302023  // 27 sw   x19, 32(x0)
03102223  // 28 sw   x17, 36(x0)
00002a03  // 29 lw   x20, 0(x0)
001a0ab3  // 30 add  x21, x20, x1   load-use
03502423  // 31 sw   x21, 40(x0)
00402b03  // 32 lw   x22, 4(x0)
03602623  // 33 sw   x22, 44(x0)    load-use as store data
07708013  // 34 addi x0, x1, 0x77   discarded
02002823  // 35 sw   x0, 48(x0)
0000000d  // M = 13
00000000 0000000f
00000004 fffffffc
00000008 0001ffff
0000000c ffff0000
00000010 00000001
00000014 00000000
00000018 7fffffff
0000001c 00000523
00000020 00000020
00000024 00000550
00000028 00000064
0000002c fffffffc
00000030 00000000

//--- bench/datapath_tb.sv
`timescale 1ns/1ns

module datapath_tb;

    localparam int CLK_HALF_NS  = 4;
    localparam int RESET_CYCLES = 8;
    localparam int PAT_WORDS    = 256;
    localparam int DMEM_WORDS   = 64;
    // quiet cycles after the last expected store to catch strays
    localparam int DRAIN_CYCLES = 10;

    logic            clk;
    logic            arst_n_i;
    rv32_pkg::word_t instr_mem_addr;
    rv32_pkg::word_t instr_mem_rdata;
    rv32_pkg::word_t data_addr;
    rv32_pkg::word_t data_wdata;
    rv32_pkg::word_t data_rdata;
    logic            data_read;
    logic            data_write;

    // N, N program words, M, then M address/data pairs
    rv32_pkg::word_t patterns [PAT_WORDS];
    rv32_pkg::word_t dmem [DMEM_WORDS];
    int              prog_len;
    int              store_total;
    logic            patterns_loaded = 1'b0;

    // updated only by the store checker
    int              store_seen = 0;
    int              store_passes = 0;
    logic            reset_bad = 1'b0;

    datapath #(
        .RESET_PC (32'h0000_0000),
        .REG_COUNT(32)
    ) dut_i (
        .clk              (clk),
        .arst_n_i         (arst_n_i),
        .instr_mem_addr_o (instr_mem_addr),
        .instr_mem_rdata_i(instr_mem_rdata),
        .data_addr_o      (data_addr),
        .data_wdata_o     (data_wdata),
        .data_rdata_i     (data_rdata),
        .data_read_o      (data_read),
        .data_write_o     (data_write)
    );

    function automatic rv32_pkg::word_t pattern_word(int pos);
        return patterns[pos[7:0]];
    endfunction

    // nops past the end of the program
    function automatic rv32_pkg::word_t instr_at(rv32_pkg::word_t addr);
        if (addr[1:0] != 2'b00 || addr >= 32'(prog_len * 4)) begin
            return rv32_pkg::NOP_INSTR;
        end
        return pattern_word(int'(addr >> 2) + 1);
    endfunction

    initial clk = 1'b0;
    always #CLK_HALF_NS clk = ~clk;

    // instruction memory returns the word one edge after the address
    always @(posedge clk) begin
        instr_mem_rdata <= instr_at(instr_mem_addr);
    end

    // word-addressed data memory
    always @(posedge clk) begin
        if (data_write) begin
            dmem[data_addr[7:2]] <= data_wdata;
        end
        // load data lands on the edge after the read strobe
        if (data_read) begin
            data_rdata <= dmem[data_addr[7:2]];
        end
    end

    // stores are matched by order rather than by cycle
    always @(posedge clk) begin : store_check
        rv32_pkg::word_t exp_addr;
        rv32_pkg::word_t exp_data;
        logic            ok;
        if (!arst_n_i) begin
            // memory strobes must stay quiet during reset
            assert (!data_write && !data_read) else begin
                $display("error: data memory strobe active while reset is asserted");
                reset_bad <= 1'b1;
            end
        end else if (data_write) begin
            assert (store_seen < store_total) else begin
                $display("error: store %0d to address %h is more than the %0d expected",
                         store_seen, data_addr, store_total);
            end
            if (store_seen < store_total) begin
                exp_addr = pattern_word(prog_len + 2 + 2 * store_seen);
                exp_data = pattern_word(prog_len + 3 + 2 * store_seen);
                ok       = (data_addr == exp_addr) && (data_wdata == exp_data);
                assert (ok) else begin
                    $display("mismatch store %0d: expected addr %h data %h, actual addr %h data %h",
                             store_seen, exp_addr, exp_data, data_addr, data_wdata);
                end
                if (ok) begin
                    store_passes <= store_passes + 1;
                    $display("store %0d: pass", store_seen);
                end
            end
            store_seen <= store_seen + 1;
        end
    end

    // bound scales with program length and store count
    initial begin : watchdog
        int limit;
        wait (patterns_loaded);
        limit = prog_len + 2 * store_total + 60;
        repeat (limit) @(posedge clk);
        $display("error: timeout after %0d cycles with %0d of %0d stores seen",
                 limit, store_seen, store_total);
        $display("Simulation failed");
        $finish;
    end

    initial begin
        int   passes;
        int   tests;
        logic count_ok;
        arst_n_i        = 1'b0;
        instr_mem_rdata = rv32_pkg::NOP_INSTR;
        data_rdata      = '0;
        // zero-filled data memory
        for (int i = 0; i < DMEM_WORDS; i++) begin
            dmem[i] <= '0;
        end
        $readmemh("bench/datapath_patterns.hex", patterns);
        prog_len        = int'(patterns[0]);
        store_total     = int'(pattern_word(prog_len + 1));
        patterns_loaded = 1'b1;
        passes          = 0;

        repeat (RESET_CYCLES) @(posedge clk);
        arst_n_i <= 1'b1;
        // let the checker's last reset-cycle update settle
        @(posedge clk);
        if (!reset_bad) begin
            passes++;
            $display("reset: pass");
        end else begin
            $display("reset: strobe seen while reset was asserted");
        end

        // done once every expected store has come out
        while (store_seen < store_total) begin
            @(posedge clk);
        end
        repeat (DRAIN_CYCLES) @(posedge clk);

        count_ok = (store_seen == store_total);
        assert (count_ok) else begin
            $display("mismatch store count: expected %0d, actual %0d", store_total, store_seen);
        end
        if (count_ok) begin
            passes++;
            $display("store count: pass");
        end

        // tests are reset, one per store seen and the count
        tests  = store_seen + 2;
        passes = passes + store_passes;
        $display("tests passed %0d, failed %0d", passes, tests - passes);
        if (passes == tests) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

//--- verilog/datapath.sv
`timescale 1ns/1ns

module datapath #(
    parameter rv32_pkg::word_t RESET_PC  = 32'h0000_0000,
    parameter int              REG_COUNT = 32
) (
    input  logic            clk,
    input  logic            arst_n_i,
    output rv32_pkg::word_t instr_mem_addr_o,
    input  rv32_pkg::word_t instr_mem_rdata_i,
    output rv32_pkg::word_t data_addr_o,
    output rv32_pkg::word_t data_wdata_o,
    input  rv32_pkg::word_t data_rdata_i,
    output logic            data_read_o,
    output logic            data_write_o
);

    // IF/ID
    rv32_pkg::word_t    ifid_instr;
    logic               ifid_valid;
    // decode sources and ID/EX
    rv32_pkg::reg_idx_t id_rs1, id_rs2;
    rv32_pkg::reg_idx_t idex_rs1, idex_rs2, idex_rd;
    rv32_pkg::word_t    idex_a, idex_b, idex_imm;
    rv32_pkg::alu_op_t  idex_alu_op;
    logic               idex_use_imm, idex_we, idex_load, idex_store;
    // EX/MEM
    rv32_pkg::word_t    exmem_result, exmem_store_data;
    rv32_pkg::reg_idx_t exmem_rd;
    logic               exmem_we, exmem_load, exmem_store;
    // writeback, also the MEM/WB forwarding source
    logic               wb_we;
    rv32_pkg::reg_idx_t wb_rd;
    rv32_pkg::word_t    wb_data;
    // hazard control
    logic               stall;
    rv32_pkg::fwd_sel_t fwd_a, fwd_b;

    // ifid pc only feeds the stall re-fetch inside fetch
    fetch_unit #(.RESET_PC(RESET_PC)) fetch_i (
        .clk(clk), .arst_n_i(arst_n_i), .stall_i(stall),
        .instr_i(instr_mem_rdata_i), .instr_addr_o(instr_mem_addr_o),
        .ifid_pc_o(), .ifid_instr_o(ifid_instr), .ifid_valid_o(ifid_valid)
    );

    decode_stage #(.REG_COUNT(REG_COUNT)) decode_i (
        .clk(clk), .arst_n_i(arst_n_i), .instr_i(ifid_instr), .valid_i(ifid_valid),
        .stall_i(stall), .wb_we_i(wb_we), .wb_rd_i(wb_rd), .wb_data_i(wb_data),
        .rs1_o(id_rs1), .rs2_o(id_rs2),
        .idex_rs1_o(idex_rs1), .idex_rs2_o(idex_rs2), .idex_rd_o(idex_rd),
        .idex_a_o(idex_a), .idex_b_o(idex_b), .idex_imm_o(idex_imm),
        .idex_alu_op_o(idex_alu_op), .idex_use_imm_o(idex_use_imm),
        .idex_we_o(idex_we), .idex_load_o(idex_load), .idex_store_o(idex_store)
    );

    hazard_unit hazard_i (
        .id_rs1_i(id_rs1), .id_rs2_i(id_rs2), .ex_rs1_i(idex_rs1), .ex_rs2_i(idex_rs2),
        .ex_rd_i(idex_rd), .mem_rd_i(exmem_rd), .wb_rd_i(wb_rd),
        .ex_load_i(idex_load), .mem_we_i(exmem_we), .wb_we_i(wb_we),
        .stall_o(stall), .fwd_a_o(fwd_a), .fwd_b_o(fwd_b)
    );

    execute_stage execute_i (
        .clk(clk), .arst_n_i(arst_n_i), .a_i(idex_a), .b_i(idex_b), .imm_i(idex_imm),
        .rd_i(idex_rd), .alu_op_i(idex_alu_op), .use_imm_i(idex_use_imm),
        .we_i(idex_we), .load_i(idex_load), .store_i(idex_store),
        .fwd_a_i(fwd_a), .fwd_b_i(fwd_b), .mem_fwd_i(exmem_result), .wb_fwd_i(wb_data),
        .exmem_result_o(exmem_result), .exmem_store_data_o(exmem_store_data),
        .exmem_rd_o(exmem_rd), .exmem_we_o(exmem_we), .exmem_load_o(exmem_load),
        .exmem_store_o(exmem_store)
    );

    memory_writeback memwb_i (
        .clk(clk), .arst_n_i(arst_n_i), .result_i(exmem_result),
        .store_data_i(exmem_store_data), .rd_i(exmem_rd), .we_i(exmem_we),
        .load_i(exmem_load), .store_i(exmem_store), .data_rdata_i(data_rdata_i),
        .data_addr_o(data_addr_o), .data_wdata_o(data_wdata_o),
        .data_read_o(data_read_o), .data_write_o(data_write_o),
        .wb_we_o(wb_we), .wb_rd_o(wb_rd), .wb_data_o(wb_data)
    );

endmodule

//--- verilog/memory_writeback.sv
`timescale 1ns/1ns

module memory_writeback (
    input  logic               clk,
    input  logic               arst_n_i,
    input  rv32_pkg::word_t    result_i,
    input  rv32_pkg::word_t    store_data_i,
    input  rv32_pkg::reg_idx_t rd_i,
    input  logic               we_i,
    input  logic               load_i,
    input  logic               store_i,
    input  rv32_pkg::word_t    data_rdata_i,
    output rv32_pkg::word_t    data_addr_o,
    output rv32_pkg::word_t    data_wdata_o,
    output logic               data_read_o,
    output logic               data_write_o,
    output logic               wb_we_o,
    output rv32_pkg::reg_idx_t wb_rd_o,
    output rv32_pkg::word_t    wb_data_o
);

    rv32_pkg::word_t memwb_result;
    logic            memwb_load;

    // one strobe per load or store, memory takes the write this cycle
    assign data_addr_o  = result_i;
    assign data_wdata_o = store_data_i;
    assign data_read_o  = load_i;
    assign data_write_o = store_i;

    // MEM/WB control bits
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            wb_we_o    <= 1'b0;
            memwb_load <= 1'b0;
        end else begin
            wb_we_o    <= we_i;
            memwb_load <= load_i;
        end
    end

    // MEM/WB payload
    always_ff @(posedge clk) begin
        memwb_result <= result_i;
        wb_rd_o      <= rd_i;
    end

    // load data arrives one cycle after the read strobe
    assign wb_data_o = memwb_load ? data_rdata_i : memwb_result;

endmodule

//--- verilog/execute_stage.sv
`timescale 1ns/1ns

module execute_stage (
    input  logic               clk,
    input  logic               arst_n_i,
    input  rv32_pkg::word_t    a_i,
    input  rv32_pkg::word_t    b_i,
    input  rv32_pkg::word_t    imm_i,
    input  rv32_pkg::reg_idx_t rd_i,
    input  rv32_pkg::alu_op_t  alu_op_i,
    input  logic               use_imm_i,
    input  logic               we_i,
    input  logic               load_i,
    input  logic               store_i,
    input  rv32_pkg::fwd_sel_t fwd_a_i,
    input  rv32_pkg::fwd_sel_t fwd_b_i,
    input  rv32_pkg::word_t    mem_fwd_i,
    input  rv32_pkg::word_t    wb_fwd_i,
    output rv32_pkg::word_t    exmem_result_o,
    output rv32_pkg::word_t    exmem_store_data_o,
    output rv32_pkg::reg_idx_t exmem_rd_o,
    output logic               exmem_we_o,
    output logic               exmem_load_o,
    output logic               exmem_store_o
);

    rv32_pkg::word_t src_a;
    rv32_pkg::word_t src_b;
    rv32_pkg::word_t op_b;
    rv32_pkg::word_t result;
    logic [4:0]      shamt;

    function automatic rv32_pkg::word_t fwd_mux(rv32_pkg::fwd_sel_t sel,
                                                rv32_pkg::word_t rf, rv32_pkg::word_t mem,
                                                rv32_pkg::word_t wb);
        case (sel)
            rv32_pkg::FWD_MEM: return mem;
            rv32_pkg::FWD_WB:  return wb;
            default:           return rf;
        endcase
    endfunction

    assign src_a = fwd_mux(fwd_a_i, a_i, mem_fwd_i, wb_fwd_i);
    // forwarded rs2 is also the store data
    assign src_b = fwd_mux(fwd_b_i, b_i, mem_fwd_i, wb_fwd_i);
    assign op_b  = use_imm_i ? imm_i : src_b;
    assign shamt = op_b[4:0];

    // result doubles as the load/store address
    always_comb begin
        case (alu_op_i)
            rv32_pkg::ALU_SUB:    result = src_a - op_b;
            rv32_pkg::ALU_SLL:    result = src_a << shamt;
            rv32_pkg::ALU_SLT:    result = {31'b0, $signed(src_a) < $signed(op_b)};
            rv32_pkg::ALU_SLTU:   result = {31'b0, src_a < op_b};
            rv32_pkg::ALU_XOR:    result = src_a ^ op_b;
            rv32_pkg::ALU_SRL:    result = src_a >> shamt;
            rv32_pkg::ALU_SRA:    result = $unsigned($signed(src_a) >>> shamt);
            rv32_pkg::ALU_OR:     result = src_a | op_b;
            rv32_pkg::ALU_AND:    result = src_a & op_b;
            rv32_pkg::ALU_PASS_B: result = op_b;
            default:              result = src_a + op_b;
        endcase
    end

    // EX/MEM control bits
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            exmem_we_o    <= 1'b0;
            exmem_load_o  <= 1'b0;
            exmem_store_o <= 1'b0;
        end else begin
            exmem_we_o    <= we_i;
            exmem_load_o  <= load_i;
            exmem_store_o <= store_i;
        end
    end

    // EX/MEM payload
    always_ff @(posedge clk) begin
        exmem_result_o     <= result;
        exmem_store_data_o <= src_b;
        exmem_rd_o         <= rd_i;
    end

endmodule

//--- verilog/hazard_unit.sv
`timescale 1ns/1ns

module hazard_unit (
    input  rv32_pkg::reg_idx_t id_rs1_i,
    input  rv32_pkg::reg_idx_t id_rs2_i,
    input  rv32_pkg::reg_idx_t ex_rs1_i,
    input  rv32_pkg::reg_idx_t ex_rs2_i,
    input  rv32_pkg::reg_idx_t ex_rd_i,
    input  rv32_pkg::reg_idx_t mem_rd_i,
    input  rv32_pkg::reg_idx_t wb_rd_i,
    input  logic               ex_load_i,
    input  logic               mem_we_i,
    input  logic               wb_we_i,
    output logic               stall_o,
    output rv32_pkg::fwd_sel_t fwd_a_o,
    output rv32_pkg::fwd_sel_t fwd_b_o
);

    // producer writes a real register that the consumer reads
    function automatic logic hits(logic we, rv32_pkg::reg_idx_t rd,
                                  rv32_pkg::reg_idx_t rs);
        return we && (rd != '0) && (rd == rs);
    endfunction

    // youngest producer wins, EX/MEM before MEM/WB
    function automatic rv32_pkg::fwd_sel_t pick(rv32_pkg::reg_idx_t rs,
                                                logic mem_we, rv32_pkg::reg_idx_t mem_rd,
                                                logic wb_we, rv32_pkg::reg_idx_t wb_rd);
        if (hits(mem_we, mem_rd, rs)) begin
            return rv32_pkg::FWD_MEM;
        end
        if (hits(wb_we, wb_rd, rs)) begin
            return rv32_pkg::FWD_WB;
        end
        return rv32_pkg::FWD_RF;
    endfunction

    // load in EX feeding decode, data only exists once it reaches WB
    // one bubble is enough since MEM/WB then forwards it
    assign stall_o = hits(ex_load_i, ex_rd_i, id_rs1_i) ||
                     hits(ex_load_i, ex_rd_i, id_rs2_i);

    assign fwd_a_o = pick(ex_rs1_i, mem_we_i, mem_rd_i, wb_we_i, wb_rd_i);
    assign fwd_b_o = pick(ex_rs2_i, mem_we_i, mem_rd_i, wb_we_i, wb_rd_i);

endmodule

//--- verilog/decode_stage.sv
`timescale 1ns/1ns

module decode_stage #(
    parameter int REG_COUNT = 32
) (
    input  logic               clk,
    input  logic               arst_n_i,
    input  rv32_pkg::word_t    instr_i,
    input  logic               valid_i,
    input  logic               stall_i,
    input  logic               wb_we_i,
    input  rv32_pkg::reg_idx_t wb_rd_i,
    input  rv32_pkg::word_t    wb_data_i,
    output rv32_pkg::reg_idx_t rs1_o,
    output rv32_pkg::reg_idx_t rs2_o,
    output rv32_pkg::reg_idx_t idex_rs1_o,
    output rv32_pkg::reg_idx_t idex_rs2_o,
    output rv32_pkg::reg_idx_t idex_rd_o,
    output rv32_pkg::word_t    idex_a_o,
    output rv32_pkg::word_t    idex_b_o,
    output rv32_pkg::word_t    idex_imm_o,
    output rv32_pkg::alu_op_t  idex_alu_op_o,
    output logic               idex_use_imm_o,
    output logic               idex_we_o,
    output logic               idex_load_o,
    output logic               idex_store_o
);

    rv32_pkg::opcode_t opcode;
    rv32_pkg::word_t   rs1_data;
    rv32_pkg::word_t   rs2_data;
    rv32_pkg::word_t   imm;
    rv32_pkg::alu_op_t alu_op;
    logic              use_rs1;
    logic              use_rs2;
    logic              use_imm;
    logic              we;
    logic              load;
    logic              store;
    logic              issue;

    // funct3 picks the op, alt is instr[30]; sub only exists for OP
    function automatic rv32_pkg::alu_op_t alu_decode(logic [2:0] funct3, logic alt,
                                                     logic allow_sub);
        case (funct3)
            3'd0:    return (alt && allow_sub) ? rv32_pkg::ALU_SUB : rv32_pkg::ALU_ADD;
            3'd1:    return rv32_pkg::ALU_SLL;
            3'd2:    return rv32_pkg::ALU_SLT;
            3'd3:    return rv32_pkg::ALU_SLTU;
            3'd4:    return rv32_pkg::ALU_XOR;
            3'd5:    return alt ? rv32_pkg::ALU_SRA : rv32_pkg::ALU_SRL;
            3'd6:    return rv32_pkg::ALU_OR;
            default: return rv32_pkg::ALU_AND;
        endcase
    endfunction

    assign opcode = instr_i[6:0];

    always_comb begin
        // defaults describe an unknown opcode, which turns into a bubble
        alu_op  = rv32_pkg::ALU_ADD;
        imm     = {{20{instr_i[31]}}, instr_i[31:20]};
        use_rs1 = 1'b0;
        use_rs2 = 1'b0;
        use_imm = 1'b1;
        we      = 1'b0;
        load    = 1'b0;
        store   = 1'b0;
        case (opcode)
            rv32_pkg::OPC_OP: begin
                alu_op  = alu_decode(instr_i[14:12], instr_i[30], 1'b1);
                use_rs1 = 1'b1;
                use_rs2 = 1'b1;
                use_imm = 1'b0;
                we      = 1'b1;
            end
            rv32_pkg::OPC_OP_IMM: begin
                alu_op  = alu_decode(instr_i[14:12], instr_i[30], 1'b0);
                use_rs1 = 1'b1;
                we      = 1'b1;
            end
            rv32_pkg::OPC_LUI: begin
                // u-format
                imm    = {instr_i[31:12], 12'h000};
                alu_op = rv32_pkg::ALU_PASS_B;
                we     = 1'b1;
            end
            rv32_pkg::OPC_LOAD: begin
                // address = rs1 + i-imm
                use_rs1 = 1'b1;
                we      = 1'b1;
                load    = 1'b1;
            end
            rv32_pkg::OPC_STORE: begin
                // s-format, rs2 is the store data
                imm     = {{20{instr_i[31]}}, instr_i[31:25], instr_i[11:7]};
                use_rs1 = 1'b1;
                use_rs2 = 1'b1;
                store   = 1'b1;
            end
            default: begin
            end
        endcase
    end

    // sources only reported when actually read, keeps stalls exact
    assign rs1_o = (valid_i && use_rs1) ? instr_i[19:15] : '0;
    assign rs2_o = (valid_i && use_rs2) ? instr_i[24:20] : '0;

    // bubble on stall, invalid slot or unknown opcode
    assign issue = valid_i && !stall_i;

    register_file #(
        .REG_COUNT(REG_COUNT)
    ) regfile_i (
        .clk       (clk),
        .arst_n_i  (arst_n_i),
        .we_i      (wb_we_i),
        .rd_i      (wb_rd_i),
        .wdata_i   (wb_data_i),
        .rs1_i     (rs1_o),
        .rs2_i     (rs2_o),
        .rs1_data_o(rs1_data),
        .rs2_data_o(rs2_data)
    );

    // ID/EX control bits
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            idex_we_o    <= 1'b0;
            idex_load_o  <= 1'b0;
            idex_store_o <= 1'b0;
        end else begin
            idex_we_o    <= issue && we;
            idex_load_o  <= issue && load;
            idex_store_o <= issue && store;
        end
    end

    // ID/EX payload
    always_ff @(posedge clk) begin
        idex_rs1_o     <= rs1_o;
        idex_rs2_o     <= rs2_o;
        idex_rd_o      <= instr_i[11:7];
        idex_a_o       <= rs1_data;
        idex_b_o       <= rs2_data;
        idex_imm_o     <= imm;
        idex_alu_op_o  <= alu_op;
        idex_use_imm_o <= use_imm;
    end

endmodule

//--- verilog/fetch_unit.sv
`timescale 1ns/1ns

module fetch_unit #(
    parameter rv32_pkg::word_t RESET_PC = 32'h0000_0000
) (
    input  logic            clk,
    input  logic            arst_n_i,
    input  logic            stall_i,
    input  rv32_pkg::word_t instr_i,
    output rv32_pkg::word_t instr_addr_o,
    output rv32_pkg::word_t ifid_pc_o,
    output rv32_pkg::word_t ifid_instr_o,
    output logic            ifid_valid_o
);

    // address requested next when not stalled
    rv32_pkg::word_t pc_q;

    // stalled: ask again for the instruction held in IF/ID
    assign instr_addr_o = stall_i ? ifid_pc_o : pc_q;

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            pc_q         <= RESET_PC;
            ifid_pc_o    <= RESET_PC;
            ifid_valid_o <= 1'b0;
        end else if (!stall_i) begin
            pc_q         <= pc_q + 32'd4;
            // memory latches the matching rdata at this same edge
            ifid_pc_o    <= pc_q;
            ifid_valid_o <= 1'b1;
        end
    end

    // instruction half of IF/ID is the synchronous memory output register
    // first cycle after reset carries no fetched word yet
    assign ifid_instr_o = ifid_valid_o ? instr_i : rv32_pkg::NOP_INSTR;

endmodule

//--- verilog/register_file.sv
`timescale 1ns/1ns

module register_file #(
    parameter int REG_COUNT = 32
) (
    input  logic               clk,
    input  logic               arst_n_i,
    input  logic               we_i,
    input  rv32_pkg::reg_idx_t rd_i,
    input  rv32_pkg::word_t    wdata_i,
    input  rv32_pkg::reg_idx_t rs1_i,
    input  rv32_pkg::reg_idx_t rs2_i,
    output rv32_pkg::word_t    rs1_data_o,
    output rv32_pkg::word_t    rs2_data_o
);

    rv32_pkg::word_t regs_q [REG_COUNT];

    // entry 0 is never written, so it stays zero after reset
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            for (int i = 0; i < REG_COUNT; i++) begin
                regs_q[i] <= '0;
            end
        end else if (we_i && rd_i != '0) begin
            regs_q[rd_i] <= wdata_i;
        end
    end

    // write-through, wb result visible in the same cycle
    assign rs1_data_o = (rs1_i == '0) ? '0 :
                        (we_i && rd_i == rs1_i) ? wdata_i : regs_q[rs1_i];
    assign rs2_data_o = (rs2_i == '0) ? '0 :
                        (we_i && rd_i == rs2_i) ? wdata_i : regs_q[rs2_i];

endmodule

//--- verilog/rv32_pkg.sv
package rv32_pkg;

    // one data or address word
    typedef logic [31:0] word_t;

    // architectural register index
    typedef logic [4:0] reg_idx_t;

    // major opcode field, instr[6:0]
    typedef logic [6:0] opcode_t;

    // register-register alu ops
    localparam opcode_t OPC_OP     = 7'b0110011;
    // register-immediate alu ops
    localparam opcode_t OPC_OP_IMM = 7'b0010011;
    localparam opcode_t OPC_LUI    = 7'b0110111;
    // word loads and stores only
    localparam opcode_t OPC_LOAD   = 7'b0000011;
    localparam opcode_t OPC_STORE  = 7'b0100011;

    // addi x0, x0, 0
    localparam word_t NOP_INSTR = 32'h0000_0013;

    // alu operations, pass-b serves lui
    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND,
        ALU_PASS_B
    } alu_op_t;

    // where an execute operand comes from
    typedef enum logic [1:0] {
        FWD_RF,
        FWD_MEM,
        FWD_WB
    } fwd_sel_t;

endpackage
